// ==== fir_types_pkg.sv ====
// sample width and vector type for the FIR data path
// filter length, unique coefficient count and pipeline latency

package fir_types_pkg;

	// ************************************************************************
	// data widths
	// ************************************************************************

	// samples, pair sums, products and tree nodes all share one width
	localparam int SAMPLE_W = 18;

	// signed by meaning, arithmetic wraps mod 2^SAMPLE_W
	typedef logic [SAMPLE_W-1:0] sample_t;

	// ************************************************************************
	// filter geometry
	// ************************************************************************

	localparam int N_TAPS = 22;

	// symmetric filter, one coefficient per tap pair
	localparam int N_UNIQ = (N_TAPS + 1) / 2;

	// levels of the registered adder tree
	localparam int TREE_DEPTH = $clog2(N_UNIQ);

	// ************************************************************************
	// pipeline latency, counted in enabled edges
	// ************************************************************************

	// input shift register
	localparam int TAP_LINE_LAT = 1;

	// pre-add register plus multiply register
	localparam int PREADD_MULT_LAT = 2;

	// i_in sampled to matching o_out
	localparam int LATENCY = TAP_LINE_LAT + PREADD_MULT_LAT + TREE_DEPTH;

endpackage

// ==== fir_coeff_pkg.sv ====
// coefficient vector type
// constant table of the unique coefficients of the symmetric filter

package fir_coeff_pkg;

	localparam int COEFF_W = 18;

	typedef logic [COEFF_W-1:0] coeff_t;

	// ************************************************************************
	// coefficient table
	// ************************************************************************

	// index k weights the pair of taps k and N_TAPS-1-k
	// negative values are stored in two's complement
	localparam coeff_t COEFFS [fir_types_pkg::N_UNIQ] = '{
		18'd88,
		18'd0,
		-18'd97,
		-18'd197,
		-18'd294,
		-18'd380,
		-18'd447,
		-18'd490,
		-18'd504,
		-18'd481,
		-18'd420
	};

endpackage

// ==== fir_tap_line.sv ====
// input shift register holding the most recent DEPTH samples
// tap 0 is the newest sample

`timescale 1ns/100ps

module fir_tap_line #(
	parameter int DEPTH = 22
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              i_clk_ena,
	input  fir_types_pkg::sample_t            i_sample,
	output fir_types_pkg::sample_t [DEPTH-1:0] o_taps
);

	// shift on every enabled edge, the valid flag plays no part here
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_taps <= '0;
		end else if (i_clk_ena) begin
			o_taps <= {o_taps[DEPTH-2:0], i_sample};
		end
	end

	// ************************************************************************
	// checks
	// ************************************************************************

	// the whole history freezes while the enable is low
	a_taps_hold: assert property (
		@(posedge clk) disable iff (reset)
		!i_clk_ena |=> $stable(o_taps)
	) else $error("tap line changed on an edge with clk_ena low");

endmodule

// ==== fir_preadd_mult.sv ====
// symmetric pre-adders, one register stage
// coefficient multipliers, one register stage, product kept to SAMPLE_W bits

`timescale 1ns/100ps

module fir_preadd_mult #(
	parameter int N_TAPS = 22
) (
	input  logic                                              clk,
	input  logic                                              i_clk_ena,
	input  fir_types_pkg::sample_t [N_TAPS-1:0]               i_taps,
	output fir_types_pkg::sample_t [(N_TAPS + 1) / 2 - 1:0] o_products
);

	import fir_types_pkg::*;
	import fir_coeff_pkg::*;

	// one lane per tap pair, plus the middle tap alone when N_TAPS is odd
	localparam int N_PAIRS = N_TAPS / 2;
	localparam int N_LANES = (N_TAPS + 1) / 2;

	sample_t [N_LANES-1:0] pair_sum_q;
	sample_t [N_LANES-1:0] pair_sum_d;

	// the coefficient table must cover every lane
	if (N_LANES > $size(COEFFS)) begin : g_coeff_check
		$error("fir_preadd_mult: %0d lanes but only %0d coefficients",
			N_LANES, $size(COEFFS));
	end

	// ************************************************************************
	// pre-add
	// ************************************************************************

	for (genvar k = 0; k < N_PAIRS; k++) begin : g_pair
		// outer taps meet first, k and its mirror
		assign pair_sum_d[k] = i_taps[k] + i_taps[N_TAPS-1-k];
	end

	if (N_TAPS % 2 == 1) begin : g_middle
		// centre tap has no partner
		assign pair_sum_d[N_LANES-1] = i_taps[N_PAIRS];
	end

	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			pair_sum_q <= pair_sum_d;
		end
	end

	// ************************************************************************
	// multiply
	// ************************************************************************

	// low bits of the product are the same for signed and unsigned operands
	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int k = 0; k < N_LANES; k++) begin
				o_products[k] <= pair_sum_q[k] * COEFFS[k];
			end
		end
	end

endmodule

// ==== fir_adder_tree.sv ====
// registered binary adder tree reducing N_INPUTS lanes to one sum
// odd lanes pass a level through a bye register to stay aligned

`timescale 1ns/100ps

module fir_adder_tree #(
	parameter int N_INPUTS = 11
) (
	input  logic                                 clk,
	input  logic                                 i_clk_ena,
	input  fir_types_pkg::sample_t [N_INPUTS-1:0] i_lanes,
	output fir_types_pkg::sample_t               o_sum
);

	import fir_types_pkg::*;

	// one register level per halving of the lane count
	localparam int DEPTH = $clog2(N_INPUTS);

	// lanes entering a given level
	function automatic int lanes_at(input int level);
		int n;
		n = N_INPUTS;
		for (int i = 0; i < level; i++) begin
			n = (n + 1) / 2;
		end
		return n;
	endfunction

	if (N_INPUTS < 2) begin : g_size_check
		$error("fir_adder_tree: needs at least two lanes, got %0d", N_INPUTS);
	end

	// ************************************************************************
	// tree levels
	// ************************************************************************

	for (genvar l = 0; l < DEPTH; l++) begin : g_level
		localparam int N_IN  = lanes_at(l);
		localparam int N_OUT = lanes_at(l + 1);

		sample_t [N_IN-1:0]  lane_in;
		sample_t [N_OUT-1:0] lane_q;

		if (l == 0) begin : g_first
			assign lane_in = i_lanes;
		end else begin : g_next
			assign lane_in = g_level[l-1].lane_q;
		end

		always_ff @(posedge clk) begin
			if (i_clk_ena) begin
				// adjacent pairs
				for (int p = 0; p < N_IN / 2; p++) begin
					lane_q[p] <= lane_in[2*p] + lane_in[2*p+1];
				end
				// bye register for the odd lane out
				if (N_IN % 2 == 1) begin
					lane_q[N_OUT-1] <= lane_in[N_IN-1];
				end
			end
		end
	end

	// last level holds a single lane
	assign o_sum = g_level[DEPTH-1].lane_q[0];

endmodule

// ==== fir_valid_delay.sv ====
// valid flag delay line, matched to the data path latency

`timescale 1ns/100ps

module fir_valid_delay #(
	parameter int DEPTH = 7
) (
	input  logic clk,
	input  logic reset,
	input  logic i_clk_ena,
	input  logic i_valid,
	output logic o_valid
);

	// bit 0 is the flag sampled on the latest enabled edge
	logic [DEPTH-1:0] valid_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q <= '0;
		end else if (i_clk_ena) begin
			valid_q <= {valid_q[DEPTH-2:0], i_valid};
		end
	end

	assign o_valid = valid_q[DEPTH-1];

	// an X on the input must not reach the output flag
	a_valid_known: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(o_valid)
	) else $error("o_valid is unknown after reset");

endmodule

// ==== fir_top.sv ====
// 22-tap symmetric FIR filter, top level
// tap line, pre-add and multiply, adder tree and valid delay

`timescale 1ns/100ps

module fir_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   i_clk_ena,
	input  logic                   i_valid,
	input  fir_types_pkg::sample_t i_in,
	output logic                   o_valid,
	output fir_types_pkg::sample_t o_out
);

	import fir_types_pkg::*;

	sample_t [N_TAPS-1:0] taps;
	sample_t [N_UNIQ-1:0] products;

	// ************************************************************************
	// data path
	// ************************************************************************

	fir_tap_line #(
		.DEPTH     (N_TAPS)
	) fir_tap_line_i (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_sample  (i_in),
		.o_taps    (taps)
	);

	fir_preadd_mult #(
		.N_TAPS     (N_TAPS)
	) fir_preadd_mult_i (
		.clk        (clk),
		.i_clk_ena  (i_clk_ena),
		.i_taps     (taps),
		.o_products (products)
	);

	fir_adder_tree #(
		.N_INPUTS  (N_UNIQ)
	) fir_adder_tree_i (
		.clk       (clk),
		.i_clk_ena (i_clk_ena),
		.i_lanes   (products),
		.o_sum     (o_out)
	);

	// ************************************************************************
	// valid flag, delayed by the full data path latency
	// ************************************************************************

	fir_valid_delay #(
		.DEPTH     (LATENCY)
	) fir_valid_delay_i (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.o_valid   (o_valid)
	);

endmodule

// ==== tb_fir_top.sv ====
// testbench for the 22-tap symmetric FIR filter
// clock, reset, stimulus tasks, reference model, assertions and report

`timescale 1ns/100ps

module tb_fir_top;

	import fir_types_pkg::*;
	import fir_coeff_pkg::*;

	localparam int SEED         = 32'hf501;
	localparam int RESET_CYCLES = 8;
	localparam int RESET_TAIL   = LATENCY + 4;
	localparam int IMPULSE_LEN  = 2 * N_TAPS + LATENCY + 1;
	localparam int RANDOM_LEN   = 500;
	localparam int STALL_LEN    = 800;
	localparam int GAP_LEN      = 500;
	localparam int DRAIN_LEN    = 5 * (LATENCY + 1);
	localparam int TEST_CYCLES  = RESET_CYCLES + RESET_TAIL + IMPULSE_LEN + RANDOM_LEN
		+ STALL_LEN + GAP_LEN + DRAIN_LEN;
	// about twice the length of all tests
	localparam int MAX_CYCLES   = 2 * TEST_CYCLES;

	logic    clk;
	logic    reset;
	logic    i_clk_ena;
	logic    i_valid;
	sample_t i_in;
	logic    o_valid;
	sample_t o_out;

	// reference model state
	sample_t             history [N_TAPS];
	logic [SAMPLE_W:0]   exp_q [$];
	logic [SAMPLE_W:0]   model_entry;
	sample_t             exp_out;
	logic                exp_valid;

	int fail_count;
	int tests_passed;
	int tests_failed;
	int checked_outputs;
	int cycle_count;

	fir_top fir_top_i (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_in      (i_in),
		.o_valid   (o_valid),
		.o_out     (o_out)
	);

	always #2 clk = ~clk;

	// ************************************************************************
	// reference model
	// ************************************************************************

	// y = sum of c[k] * (x[n-k] + x[n-21+k]) mod 2^SAMPLE_W
	function automatic sample_t expected_output(input sample_t h [N_TAPS]);
		sample_t acc;
		acc = '0;
		for (int k = 0; k < N_UNIQ; k++) begin
			acc = acc + sample_t'((h[k] + h[N_TAPS-1-k]) * COEFFS[k]);
		end
		return acc;
	endfunction

	// an entry leaves the queue on the edge that loads it into the DUT output
	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < N_TAPS; i++) begin
				history[i] = '0;
			end
			exp_q.delete();
			exp_out <= '0;
			exp_valid <= 1'b0;
		end else if (i_clk_ena) begin
			for (int i = N_TAPS - 1; i > 0; i--) begin
				history[i] = history[i-1];
			end
			history[0] = i_in;
			exp_q.push_back({i_valid, expected_output(history)});
			if (exp_q.size() >= LATENCY) begin
				model_entry = exp_q.pop_front();
				exp_valid <= model_entry[SAMPLE_W];
				exp_out <= model_entry[SAMPLE_W-1:0];
				if (model_entry[SAMPLE_W]) begin
					checked_outputs++;
				end
			end
		end
	end

	// ************************************************************************
	// checks
	// ************************************************************************

	function automatic void note_failure(input string msg);
		fail_count++;
		$display("[FAIL] time %0d ns: %s", $time, msg);
	endfunction

	a_reset_quiet: assert property (@(posedge clk) reset |-> !o_valid)
		else note_failure("o_valid high while reset is asserted");

	a_valid_match: assert property (
		@(posedge clk) disable iff (reset)
		o_valid == exp_valid
	) else note_failure($sformatf("o_valid %0b, expected %0b", $sampled(o_valid),
		$sampled(exp_valid)));

	a_out_match: assert property (
		@(posedge clk) disable iff (reset)
		exp_valid |-> o_out == exp_out
	) else note_failure($sformatf("o_out %05h, expected %05h", $sampled(o_out),
		$sampled(exp_out)));

	// outputs freeze on every edge with the enable low
	a_stall_hold: assert property (
		@(posedge clk) disable iff (reset)
		!i_clk_ena |=> $stable(o_valid) && (!o_valid || $stable(o_out))
	) else note_failure("outputs changed on an edge with clk_ena low");

	// ************************************************************************
	// stimulus
	// ************************************************************************

	task automatic drive_cycle(input logic ena, input logic valid, input sample_t sample);
		@(posedge clk);
		i_clk_ena <= ena;
		i_valid <= valid;
		i_in <= sample;
	endtask

	task automatic close_test(input string name, input int fails_before);
		@(negedge clk);
		if (fail_count == fails_before) begin
			tests_passed++;
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, fail_count - fails_before);
		end
	endtask

	task automatic check_reset();
		int fails_before;
		fails_before = fail_count;
		// valid samples during reset must never show up at the output
		repeat (RESET_CYCLES) drive_cycle(1'b1, 1'b1, sample_t'($urandom));
		reset <= 1'b0;
		repeat (RESET_TAIL) drive_cycle(1'b1, 1'b1, sample_t'($urandom));
		close_test("reset", fails_before);
	endtask

	task automatic send_impulse();
		int fails_before;
		fails_before = fail_count;
		// clear the history first
		repeat (N_TAPS) drive_cycle(1'b1, 1'b1, '0);
		drive_cycle(1'b1, 1'b1, sample_t'(1));
		repeat (IMPULSE_LEN - N_TAPS - 1) drive_cycle(1'b1, 1'b1, '0);
		close_test("impulse", fails_before);
	endtask

	task automatic stream_random();
		int fails_before;
		fails_before = fail_count;
		repeat (RANDOM_LEN) drive_cycle(1'b1, 1'b1, sample_t'($urandom));
		repeat (LATENCY + 1) drive_cycle(1'b1, 1'b1, sample_t'($urandom));
		close_test("random stream", fails_before);
	endtask

	task automatic stall_randomly();
		int fails_before;
		fails_before = fail_count;
		repeat (STALL_LEN) drive_cycle(1'($urandom_range(1, 0)), 1'b1, sample_t'($urandom));
		repeat (LATENCY + 1) drive_cycle(1'b1, 1'b1, sample_t'($urandom));
		close_test("stall", fails_before);
	endtask

	task automatic insert_valid_gaps();
		int fails_before;
		fails_before = fail_count;
		repeat (GAP_LEN) drive_cycle(1'b1, 1'($urandom_range(1, 0)), sample_t'($urandom));
		repeat (LATENCY + 1) drive_cycle(1'b1, 1'b0, sample_t'($urandom));
		close_test("valid gaps", fails_before);
	endtask

	// ************************************************************************
	// run control
	// ************************************************************************

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("run timed out after %0d cycles before all tests finished", cycle_count);
			$display("** FAIL **");
			$finish;
		end
	end

	initial begin
		void'($urandom(SEED));
		clk = 1'b0;
		reset = 1'b1;
		i_clk_ena = 1'b0;
		i_valid = 1'b0;
		i_in = '0;
		fail_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		checked_outputs = 0;
		cycle_count = 0;

		check_reset();
		send_impulse();
		stream_random();
		stall_randomly();
		insert_valid_gaps();

		$display("tests passed: %0d, tests failed: %0d, outputs checked: %0d, errors: %0d",
			tests_passed, tests_failed, checked_outputs, fail_count);
		if (tests_failed == 0 && fail_count == 0 && checked_outputs > 0) begin
			$display("** PASS **");
		end else begin
			if (checked_outputs == 0) begin
				$display("no valid output reached the checks");
			end
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== fir22.f ====
fir_types_pkg.sv
fir_coeff_pkg.sv
fir_tap_line.sv
fir_preadd_mult.sv
fir_adder_tree.sv
fir_valid_delay.sv
fir_top.sv
tb_fir_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the FIR testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
RUN_LOG=sim.log

verilator --binary --assert --top-module tb_fir_top -f fir22.f -o tb_fir_top \
	> "$BUILD_LOG" 2>&1 \
	|| { cat "$BUILD_LOG"; echo "build failed"; exit 1; }

./obj_dir/tb_fir_top > "$RUN_LOG" 2>&1 \
	|| echo "simulator returned a non-zero status"

cat "$RUN_LOG"

grep -q '^\*\* PASS \*\*$' "$RUN_LOG" \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed"; exit 1; }
